//--- Makefile
# Verilator build of tbTop, pass or fail is read from the simulation log
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tbTop and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tbTop -f project.f -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- common/lsuPkg.sv
// shared constants for the Sv32 load/store path and xlen stays 32 because walks assume Sv32
package lsuPkg;

  ////////////////////////////////////////
  // widths and access encodings
  ////////////////////////////////////////

  // data and address width of the whole path
  localparam int xlen = 32;

  // access kind driven alongside every request
  localparam logic [1:0] memRwNone  = 2'b00;
  localparam logic [1:0] memRwWrite = 2'b01;
  localparam logic [1:0] memRwRead  = 2'b10;

  // access size codes as they appear in RISC-V load and store funct3
  localparam logic [2:0] funct3Byte  = 3'b000;
  localparam logic [2:0] funct3Half  = 3'b001;
  localparam logic [2:0] funct3Word  = 3'b010;
  localparam logic [2:0] funct3ByteU = 3'b100;
  localparam logic [2:0] funct3HalfU = 3'b101;

  ////////////////////////////////////////
  // Sv32 fields
  ////////////////////////////////////////

  // page offset width and the width of each VPN slice
  localparam int pageShift = 12;
  localparam int vpnBits   = 10;

  // PTE flag positions, the PPN begins right above the RSW bits
  localparam int pteV   = 0;
  localparam int pteR   = 1;
  localparam int pteW   = 2;
  localparam int pteX   = 3;
  localparam int ppnLsb = 10;

  // state types, the arbiter states get explicit distinct codes
  typedef enum logic [1:0] {
    arbReady      = 2'b00,
    arbPtwPending = 2'b01,
    arbPtwActive  = 2'b10
  } arbState;

  typedef enum logic [2:0] {
    walkIdle, walkLevel1, walkLevel0, walkDone, walkFault
  } walkState;

endpackage

//--- design/memSubsystem.sv
// top of the data-side LSU where the CPU and one walker client share a single memory port
`timescale 1ns/1ps

module memSubsystem #(
  parameter int memWords    = 4096,
  parameter int missLatency = 3
) (
  input  logic                                      clk,
  input  logic                                      rstN,
  // CPU demand port
  input  logic [1:0]                                memRw,
  input  logic [2:0]                                funct3,
  input  logic [lsuPkg::xlen-1:0]                   memAdr,
  input  logic [lsuPkg::xlen-1:0]                   writeData,
  output logic [lsuPkg::xlen-1:0]                   readData,
  output logic                                      dataMisaligned,
  output logic                                      committed,
  output logic                                      dCacheStall,
  // walker client port
  input  logic [lsuPkg::xlen-lsuPkg::pageShift-1:0] satpPpn,
  input  logic                                      walkReq,
  input  logic [lsuPkg::xlen-1:0]                   walkVAdr,
  output logic                                      walkDone,
  output logic                                      walkFault,
  output logic [lsuPkg::xlen-1:0]                   walkPAdr
);
  import lsuPkg::*;

  // walker to arbiter
  logic            hptwTranslate, hptwReady;
  logic [xlen-1:0] hptwPAdr, hptwReadPte;

  // arbiter to memory and back
  logic [1:0]      lsuMemRw;
  logic [2:0]      lsuFunct3;
  logic [xlen-1:0] lsuAdr, lsuWriteData, lsuReadData;
  logic            lsuCommitted, lsuMisaligned, dataStall;

  lsuArb arb (
    .clk, .rstN,
    .hptwTranslate, .hptwPAdr, .hptwReadPte, .hptwReady,
    .memRw, .funct3, .memAdr, .writeData,
    .readData, .committed, .dataMisaligned, .dCacheStall,
    .lsuMemRw, .lsuFunct3, .lsuAdr, .lsuWriteData,
    .lsuReadData, .lsuCommitted, .lsuMisaligned, .dataStall
  );

  pageTableWalker ptw (
    .clk, .rstN,
    .satpPpn, .walkReq, .walkVAdr,
    .walkDone, .walkFault, .walkPAdr,
    .hptwTranslate, .hptwPAdr, .hptwReadPte, .hptwReady
  );

  // the stall length and the array size come only from this level
  dataMemory #(
    .memWords   (memWords),
    .missLatency(missLatency)
  ) mem (
    .clk, .rstN,
    .lsuMemRw, .lsuFunct3, .lsuAdr, .lsuWriteData,
    .lsuReadData, .lsuCommitted, .lsuMisaligned, .dataStall
  );

endmodule

//--- lsu/dataMemory.sv
// data memory model with a fixed stall and address wrap modulo memWords which has no contents reset
`timescale 1ns/1ps

module dataMemory #(
  parameter int memWords    = 4096,
  parameter int missLatency = 3
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [1:0]              lsuMemRw,
  input  logic [2:0]              lsuFunct3,
  input  logic [lsuPkg::xlen-1:0] lsuAdr,
  input  logic [lsuPkg::xlen-1:0] lsuWriteData,
  output logic [lsuPkg::xlen-1:0] lsuReadData,
  output logic                    lsuCommitted,
  output logic                    lsuMisaligned,
  output logic                    dataStall
);
  import lsuPkg::*;

  localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;
  localparam int cntW = (missLatency > 0) ? $clog2(missLatency + 1) : 1;

  logic [xlen-1:0] mem [memWords];
  logic [idxW-1:0] wordIdx;
  logic [cntW-1:0] stallCnt;
  logic [xlen-1:0] rdWord, wrWord;
  logic [7:0]      rdByte;
  logic [15:0]     rdHalf;
  logic            misAlign, active;

  ////////////////////////////////////////
  // address checks and stall
  ////////////////////////////////////////

  // halves need an even address and words need the low two bits clear
  always_comb begin
    case (lsuFunct3)
      funct3Half, funct3HalfU: misAlign = lsuAdr[0];
      funct3Word:              misAlign = |lsuAdr[1:0];
      default:                 misAlign = 1'b0;
    endcase
  end

  // a misaligned request is flagged at once and never reaches the array
  assign lsuMisaligned = (lsuMemRw != memRwNone) & misAlign;
  assign active        = (lsuMemRw != memRwNone) & ~misAlign;

  // stall for missLatency cycles counted from the first cycle of a request
  assign dataStall    = active & (stallCnt < cntW'(missLatency));
  assign lsuCommitted = active & (stallCnt != '0);

  // the count restarts whenever an access completes or the port goes idle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stallCnt <= '0;
    end else if (dataStall) begin
      stallCnt <= stallCnt + 1'b1;
    end else begin
      stallCnt <= '0;
    end
  end

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  assign wordIdx = idxW'(lsuAdr[xlen-1:2] % memWords);
  assign rdWord  = mem[wordIdx];
  assign rdByte  = rdWord[{lsuAdr[1:0], 3'b000} +: 8];
  assign rdHalf  = rdWord[{lsuAdr[1], 4'b0000} +: 16];

  // sign or zero extension follows the funct3 code
  always_comb begin
    case (lsuFunct3)
      funct3Byte:  lsuReadData = {{(xlen-8){rdByte[7]}}, rdByte};
      funct3Half:  lsuReadData = {{(xlen-16){rdHalf[15]}}, rdHalf};
      funct3ByteU: lsuReadData = {{(xlen-8){1'b0}}, rdByte};
      funct3HalfU: lsuReadData = {{(xlen-16){1'b0}}, rdHalf};
      default:     lsuReadData = rdWord;
    endcase
  end

  // narrow stores merge into the word that is already there
  always_comb begin
    wrWord = rdWord;
    case (lsuFunct3)
      funct3Byte, funct3ByteU: wrWord[{lsuAdr[1:0], 3'b000} +: 8]  = lsuWriteData[7:0];
      funct3Half, funct3HalfU: wrWord[{lsuAdr[1], 4'b0000} +: 16] = lsuWriteData[15:0];
      default:                 wrWord = lsuWriteData;
    endcase
  end

  // the store lands on the edge that ends its last stall cycle
  always_ff @(posedge clk) begin
    if (active && !dataStall && lsuMemRw == memRwWrite) begin
      mem[wordIdx] <= wrWord;
    end
  end

endmodule

//--- lsu/lsuArb.sv
// shares one memory port between CPU and walker and the walker holds it for a whole walk
`timescale 1ns/1ps

module lsuArb (
  input  logic                    clk,
  input  logic                    rstN,
  // walker side
  input  logic                    hptwTranslate,
  input  logic [lsuPkg::xlen-1:0] hptwPAdr,
  output logic [lsuPkg::xlen-1:0] hptwReadPte,
  output logic                    hptwReady,
  // CPU side
  input  logic [1:0]              memRw,
  input  logic [2:0]              funct3,
  input  logic [lsuPkg::xlen-1:0] memAdr,
  input  logic [lsuPkg::xlen-1:0] writeData,
  output logic [lsuPkg::xlen-1:0] readData,
  output logic                    committed,
  output logic                    dataMisaligned,
  output logic                    dCacheStall,
  // memory side
  output logic [1:0]              lsuMemRw,
  output logic [2:0]              lsuFunct3,
  output logic [lsuPkg::xlen-1:0] lsuAdr,
  output logic [lsuPkg::xlen-1:0] lsuWriteData,
  input  logic [lsuPkg::xlen-1:0] lsuReadData,
  input  logic                    lsuCommitted,
  input  logic                    lsuMisaligned,
  input  logic                    dataStall
);
  import lsuPkg::*;

  arbState curState, nextState;
  logic    selPtw;

  ////////////////////////////////////////
  // ownership FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      curState <= arbReady;
    end else begin
      curState <= nextState;
    end
  end

  // a CPU access that is already stalling keeps the port until it completes
  // and only then does the walker get it
  always_comb begin
    nextState = curState;
    case (curState)
      arbReady: begin
        if (hptwTranslate) begin
          nextState = dataStall ? arbPtwPending : arbPtwActive;
        end
      end
      arbPtwPending: begin
        if (!dataStall) begin
          nextState = arbPtwActive;
        end
      end
      // stay for every PTE read of the walk and leave once translate drops
      arbPtwActive: begin
        if (!hptwTranslate) begin
          nextState = arbReady;
        end
      end
      default: nextState = arbReady;
    endcase
  end

  assign selPtw = (curState == arbPtwActive);

  ////////////////////////////////////////
  // request and response steering
  ////////////////////////////////////////

  // the walker only ever reads whole words
  // in the last active cycle translate is already low so the port goes idle
  assign lsuMemRw     = selPtw ? (hptwTranslate ? memRwRead : memRwNone) : memRw;
  assign lsuFunct3    = selPtw ? funct3Word : funct3;
  assign lsuAdr       = selPtw ? hptwPAdr : memAdr;
  assign lsuWriteData = selPtw ? '0 : writeData;

  // the CPU sees nothing from memory while the walker owns the port
  assign readData       = selPtw ? '0 : lsuReadData;
  assign committed      = selPtw ? 1'b0 : lsuCommitted;
  assign dataMisaligned = selPtw ? 1'b0 : lsuMisaligned;
  assign dCacheStall    = selPtw ? 1'b1 : dataStall;

  // a PTE read completes when the walker owns the port and memory stops stalling
  assign hptwReadPte = selPtw ? lsuReadData : '0;
  assign hptwReady   = selPtw & hptwTranslate & ~dataStall;

endmodule

//--- lsu/pageTableWalker.sv
// two-level Sv32 walker that keeps the low 32 bits of physical addresses and checks no permissions
`timescale 1ns/1ps

module pageTableWalker (
  input  logic                                      clk,
  input  logic                                      rstN,
  // client side
  input  logic [lsuPkg::xlen-lsuPkg::pageShift-1:0] satpPpn,
  input  logic                                      walkReq,
  input  logic [lsuPkg::xlen-1:0]                   walkVAdr,
  output logic                                      walkDone,
  output logic                                      walkFault,
  output logic [lsuPkg::xlen-1:0]                   walkPAdr,
  // arbiter side
  output logic                                      hptwTranslate,
  output logic [lsuPkg::xlen-1:0]                   hptwPAdr,
  input  logic [lsuPkg::xlen-1:0]                   hptwReadPte,
  input  logic                                      hptwReady
);
  import lsuPkg::*;

  // PPN bits that still fit into a 32 bit physical address
  localparam int ppnW = xlen - pageShift;

  walkState             curState, nextState;
  logic [xlen-1:0]      vAdr;
  logic [xlen-1:0]      l0Adr;
  logic [xlen-1:0]      pAdrReg;
  logic [ppnW-1:0]      ptePpn;
  logic [vpnBits-1:0]   vpn1, vpn0;
  logic [pageShift-1:0] pageOff;
  logic                 pteValid, pteLeaf;

  ////////////////////////////////////////
  // PTE decode
  ////////////////////////////////////////

  assign vpn1    = vAdr[pageShift+vpnBits +: vpnBits];
  assign vpn0    = vAdr[pageShift +: vpnBits];
  assign pageOff = vAdr[pageShift-1:0];

  assign ptePpn   = hptwReadPte[ppnLsb +: ppnW];
  assign pteValid = hptwReadPte[pteV];
  assign pteLeaf  = hptwReadPte[pteR] | hptwReadPte[pteX];

  ////////////////////////////////////////
  // walk FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      curState <= walkIdle;
    end else begin
      curState <= nextState;
    end
  end

  // the result states share their names with the output ports
  // so they are always written with the package scope here
  always_comb begin
    nextState = curState;
    case (curState)
      walkIdle: begin
        if (walkReq) begin
          nextState = walkLevel1;
        end
      end
      walkLevel1: begin
        if (hptwReady) begin
          if (!pteValid)    nextState = lsuPkg::walkFault;
          else if (pteLeaf) nextState = lsuPkg::walkDone;
          else              nextState = walkLevel0;
        end
      end
      // a pointer at level 0 has nowhere left to go
      walkLevel0: begin
        if (hptwReady) begin
          if (pteValid && pteLeaf) nextState = lsuPkg::walkDone;
          else                     nextState = lsuPkg::walkFault;
        end
      end
      // hold the result until the client drops its request
      lsuPkg::walkDone, lsuPkg::walkFault: begin
        if (!walkReq) begin
          nextState = walkIdle;
        end
      end
      default: nextState = walkIdle;
    endcase
  end

  // the virtual address is sampled once so the client may change it mid walk
  // the result address is only meaningful when no fault is flagged
  always_ff @(posedge clk) begin
    if (curState == walkIdle && walkReq) begin
      vAdr <= walkVAdr;
    end
    if (curState == walkLevel1 && hptwReady) begin
      l0Adr   <= {ptePpn, vpn0, 2'b00};
      pAdrReg <= {ptePpn[ppnW-1:vpnBits], vpn0, pageOff};
    end
    if (curState == walkLevel0 && hptwReady) begin
      pAdrReg <= {ptePpn, pageOff};
    end
  end

  // the first read indexes the root table by VPN[1]
  assign hptwPAdr      = (curState == walkLevel0) ? l0Adr : {satpPpn, vpn1, 2'b00};
  assign hptwTranslate = (curState == walkLevel1) || (curState == walkLevel0);

  assign walkDone  = (curState == lsuPkg::walkDone) || (curState == lsuPkg::walkFault);
  assign walkFault = (curState == lsuPkg::walkFault);
  assign walkPAdr  = pAdrReg;

endmodule

//--- project.f
common/lsuPkg.sv
lsu/lsuArb.sv
lsu/pageTableWalker.sv
lsu/dataMemory.sv
design/memSubsystem.sv
verification/tbChecker.sv
verification/tbTop.sv

//--- verification/tbChecker.sv
// compares DUT responses at the negedge where they are stable, expected values come from tbTop
`timescale 1ns/1ps

module tbChecker (
  input  logic        clk,
  // entry in flight and its expected results
  input  logic        cpuBusy,
  input  logic        walkBusy,
  input  logic        expLoad,
  input  logic        expMis,
  input  logic        expFault,
  input  logic [31:0] expData,
  input  logic [31:0] expPAdr,
  // DUT outputs under watch
  input  logic [31:0] readData,
  input  logic [31:0] walkPAdr,
  input  logic        dataMisaligned,
  input  logic        committed,
  input  logic        dCacheStall,
  input  logic        walkDone,
  input  logic        walkFault,
  // summary
  input  int          missCount,
  input  logic        reportNow,
  output int          errCount
);

  int errors      = 0;
  int stallCycles = 0;

  assign errCount = errors;

  ////////////////////////////////////////
  // CPU side
  ////////////////////////////////////////

  // a CPU access completes at the first negedge with dCacheStall low
  always @(negedge clk) begin
    if (cpuBusy && dCacheStall) begin
      // an access is not committed in its first cycle but is from its second cycle on
      if (stallCycles == 0 && committed !== 1'b0) begin
        $display("FAIL committed got %h expected %h", committed, 1'b0);
        errors++;
      end
      if (stallCycles == 1 && committed !== 1'b1) begin
        $display("FAIL committed got %h expected %h", committed, 1'b1);
        errors++;
      end
      stallCycles = stallCycles + 1;
    end
    if (cpuBusy && !dCacheStall) begin
      if (dataMisaligned !== expMis) begin
        $display("FAIL dataMisaligned got %h expected %h", dataMisaligned, expMis);
        errors++;
      end
      // a misaligned request is flagged in its first cycle and never stalls
      if (expMis && stallCycles != 0) begin
        $display("misaligned access stalled for %0d cycles instead of none", stallCycles);
        errors++;
      end
      if (expMis && committed !== 1'b0) begin
        $display("FAIL committed got %h expected %h", committed, 1'b0);
        errors++;
      end
      if (expLoad && !expMis && readData !== expData) begin
        $display("FAIL readData got %h expected %h", readData, expData);
        errors++;
      end
    end
    if (!cpuBusy) begin
      stallCycles = 0;
    end
    ////////////////////////////////////////
    // walker side
    ////////////////////////////////////////
    // walkPAdr has no meaning after a fault so it is only compared on success
    if (walkBusy && walkDone) begin
      if (walkFault !== expFault) begin
        $display("FAIL walkFault got %h expected %h", walkFault, expFault);
        errors++;
      end
      if (!expFault && walkPAdr !== expPAdr) begin
        $display("FAIL walkPAdr got %h expected %h", walkPAdr, expPAdr);
        errors++;
      end
    end
  end

  always @(posedge reportNow) begin
    $display("summary: %0d value errors, %0d missing completions", errors, missCount);
  end

endmodule

//--- verification/tbTop.sv
// memSubsystem testbench at missLatency 3 with PTEs written by CPU stores and one walk at a time
`timescale 1ns/1ps

module tbTop;
  import lsuPkg::*;

  localparam int missLatency = 3;
  // per-completion bound, enough for a load queued behind a two-level walk
  localparam int waitLimit   = 4 * (missLatency + 1) + 10;
  localparam int kindStore   = 0;
  localparam int kindLoad    = 1;
  localparam int kindWalk    = 2;
  localparam int kindOverlap = 3;

  logic        clk, rstN, walkReq, dataMisaligned, committed, dCacheStall, walkDone, walkFault;
  logic [1:0]  memRw;
  logic [2:0]  funct3;
  logic [31:0] memAdr, writeData, readData, walkVAdr, walkPAdr;
  logic [19:0] satpPpn;
  // expected values handed to the checker for the entry in flight
  logic        cpuBusy, walkBusy, expLoad, expMis, expFault, reportNow;
  logic [31:0] expData, expPAdr;
  int          errCount;
  int          missCount = 0;

  // stimulus table, for an overlap entry wdT carries the walk's virtual address
  int          kindT [64];
  logic [31:0] adrT [64], wdT [64], dataT [64], pAdrT [64];
  logic [2:0]  f3T [64];
  bit          faultT [64], misT [64];
  int          numEntries = 0;
  int          idx;
  logic [31:0] lcgState = 32'h14a8813a;
  logic [31:0] r0, r1, r2, r3, merged, rnd;

  memSubsystem #(.memWords(4096), .missLatency(missLatency)) dut (
    .clk, .rstN, .memRw, .funct3, .memAdr, .writeData,
    .readData, .dataMisaligned, .committed, .dCacheStall,
    .satpPpn, .walkReq, .walkVAdr, .walkDone, .walkFault, .walkPAdr
  );

  tbChecker chk (
    .clk, .cpuBusy, .walkBusy, .expLoad, .expMis, .expFault, .expData, .expPAdr,
    .readData, .walkPAdr, .dataMisaligned, .committed, .dCacheStall, .walkDone, .walkFault,
    .missCount, .reportNow, .errCount
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcgStep();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic addEntry(input int kind, input logic [31:0] adr, input logic [2:0] f3,
                          input logic [31:0] wd, input logic [31:0] data,
                          input logic [31:0] pAdr, input bit fault, input bit mis);
    kindT[numEntries]  = kind;
    adrT[numEntries]   = adr;
    f3T[numEntries]    = f3;
    wdT[numEntries]    = wd;
    dataT[numEntries]  = data;
    pAdrT[numEntries]  = pAdr;
    faultT[numEntries] = fault;
    misT[numEntries]   = mis;
    numEntries++;
  endtask

  task automatic buildTable();
    r0 = lcgStep();
    r1 = lcgStep();
    r2 = lcgStep();
    r3 = lcgStep();
    // word at 0x100 after the byte store into its second byte
    merged = {r0[31:16], r2[7:0], r0[7:0]};
    ////////////////////////////////////////
    // plain words, then narrow merges and extension
    addEntry(kindStore, 32'h100, funct3Word, r0, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h104, funct3Word, r1, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h100, funct3Word, 32'h0, r0, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h104, funct3Word, 32'h0, r1, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h101, funct3Byte, r2, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h106, funct3Half, r3, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h100, funct3Word, 32'h0, merged, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h101, funct3Byte, 32'h0, {{24{r2[7]}}, r2[7:0]}, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h101, funct3ByteU, 32'h0, {24'h0, r2[7:0]}, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h106, funct3Half, 32'h0, {{16{r3[15]}}, r3[15:0]}, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h106, funct3HalfU, 32'h0, {16'h0, r3[15:0]}, 32'h0, 1'b0, 1'b0);
    addEntry(kindLoad, 32'h104, funct3Word, 32'h0, {r3[15:0], r1[15:0]}, 32'h0, 1'b0, 1'b0);
    // misaligned accesses must leave the word at 0x100 alone
    addEntry(kindStore, 32'h102, funct3Word, r3, 32'h0, 32'h0, 1'b0, 1'b1);
    addEntry(kindLoad, 32'h105, funct3Half, 32'h0, 32'h0, 32'h0, 1'b0, 1'b1);
    addEntry(kindLoad, 32'h100, funct3Word, 32'h0, merged, 32'h0, 1'b0, 1'b0);
    ////////////////////////////////////////
    // root table at 0x2000 and one level-0 table at 0x3000
    addEntry(kindStore, 32'h2004, funct3Word, 32'h00000c01, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h2008, funct3Word, 32'h0abffc0b, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h200c, funct3Word, 32'h00000c00, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h3014, funct3Word, 32'h048d1407, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h3018, funct3Word, 32'h00000c01, 32'h0, 32'h0, 1'b0, 1'b0);
    addEntry(kindStore, 32'h3020, funct3Word, 32'h048d1406, 32'h0, 32'h0, 1'b0, 1'b0);
    // two-level leaf, superpage leaf, then the three fault cases
    addEntry(kindWalk, 32'h00405234, funct3Word, 32'h0, 32'h0, 32'h12345234, 1'b0, 1'b0);
    addEntry(kindWalk, 32'h00807abc, funct3Word, 32'h0, 32'h0, 32'h2ac07abc, 1'b0, 1'b0);
    addEntry(kindWalk, 32'h00c00000, funct3Word, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0);
    addEntry(kindWalk, 32'h00406000, funct3Word, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0);
    addEntry(kindWalk, 32'h00408000, funct3Word, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0);
    // the walk arrives while the load stalls, then the same load waits out the walk
    addEntry(kindOverlap, 32'h104, funct3Word, 32'h00405234, {r3[15:0], r1[15:0]},
             32'h12345234, 1'b0, 1'b0);
  endtask

  task automatic startCpu(input int i);
    memRw     = (kindT[i] == kindStore) ? memRwWrite : memRwRead;
    funct3    = f3T[i];
    memAdr    = adrT[i];
    writeData = (kindT[i] == kindStore) ? wdT[i] : 32'h0;
    expLoad   = (kindT[i] != kindStore);
    cpuBusy   = 1'b1;
  endtask

  task automatic endCpu();
    memRw   = memRwNone;
    cpuBusy = 1'b0;
  endtask

  // completion of a CPU access is the first negedge with dCacheStall low
  task automatic waitCpuDone();
    int n;
    n = 0;
    @(negedge clk);
    while (dCacheStall && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (dCacheStall) begin
      $display("entry %0d: CPU access did not complete within %0d cycles", idx, waitLimit);
      missCount++;
    end
  endtask

  task automatic waitWalkDone();
    int n;
    n = 0;
    @(negedge clk);
    while (!walkDone && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!walkDone) begin
      $display("entry %0d: walk did not finish within %0d cycles", idx, waitLimit);
      missCount++;
    end
  endtask

  initial begin
    clk       = 1'b0;
    rstN      = 1'b0;
    memRw     = memRwNone;
    funct3    = funct3Word;
    memAdr    = 32'h0;
    writeData = 32'h0;
    satpPpn   = 20'h2;
    walkReq   = 1'b0;
    walkVAdr  = 32'h0;
    cpuBusy   = 1'b0;
    walkBusy  = 1'b0;
    expLoad   = 1'b0;
    expMis    = 1'b0;
    expFault  = 1'b0;
    expData   = 32'h0;
    expPAdr   = 32'h0;
    reportNow = 1'b0;
    buildTable();
    repeat (4) @(posedge clk);
    #1 rstN = 1'b1;
    for (idx = 0; idx < numEntries; idx++) begin
      // idle gap of zero to three cycles taken from the top LCG bits
      rnd = lcgStep();
      repeat (rnd[31:30]) @(posedge clk);
      @(posedge clk);
      #1;
      expData  = dataT[idx];
      expPAdr  = pAdrT[idx];
      expFault = faultT[idx];
      expMis   = misT[idx];
      if (kindT[idx] == kindWalk) begin
        walkVAdr = adrT[idx];
        walkReq  = 1'b1;
        walkBusy = 1'b1;
        waitWalkDone();
        @(posedge clk);
        #1;
        walkReq  = 1'b0;
        walkBusy = 1'b0;
      end else if (kindT[idx] == kindOverlap) begin
        startCpu(idx);
        @(posedge clk);
        #1;
        walkVAdr = wdT[idx];
        walkReq  = 1'b1;
        walkBusy = 1'b1;
        waitCpuDone();
        waitWalkDone();
        @(posedge clk);
        #1;
        walkReq  = 1'b0;
        walkBusy = 1'b0;
        waitCpuDone();
        @(posedge clk);
        #1 endCpu();
      end else begin
        startCpu(idx);
        waitCpuDone();
        @(posedge clk);
        #1 endCpu();
      end
    end
    repeat (2) @(posedge clk);
    reportNow = 1'b1;
    #1;
    if (errCount == 0 && missCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // budget per entry covers two full memory accesses plus slack
  initial begin : watchdog
    int limit;
    #1;
    limit = numEntries * (2 * (missLatency + 1) + 10) + 4;
    repeat (limit) @(posedge clk);
    $display("watchdog timeout, the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
